//--- logic/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // fixed word geometry, four byte lanes
    localparam int DATA_WIDTH = 32;
    localparam int BEN_WIDTH  = DATA_WIDTH / 8;

    typedef logic [DATA_WIDTH-1:0] word_t;

    // load/store opcodes
    typedef enum logic [2:0] {
        OP_LB  = 3'd0,
        OP_LH  = 3'd1,
        OP_LW  = 3'd2,
        OP_LBU = 3'd3,
        OP_LHU = 3'd4,
        OP_SB  = 3'd5,
        OP_SH  = 3'd6,
        OP_SW  = 3'd7
    } mem_op_e;

    // byte address, only the low ADDR_WIDTH bits reach the memory
    typedef struct packed {
        mem_op_e     op;
        logic [31:0] addr;
        word_t       wdata;
    } lsu_req_t;

    typedef struct packed {
        word_t rdata;
        logic  misaligned;
    } lsu_rsp_t;

    typedef struct packed {
        logic [31:0] pc;
        word_t       instr;
    } fetch_rsp_t;

    // external program loader write
    typedef struct packed {
        logic [31:0]          addr;
        word_t                data;
        logic [BEN_WIDTH-1:0] ben;
    } prog_wr_t;

endpackage

`default_nettype wire

//--- logic/mem.sv
`timescale 1ns/1ps
`default_nettype none

module mem #(
    parameter int ADDR_WIDTH = 8
) (
    input  wire logic                           clk,
    input  wire logic                           rst_n,

    // port a, fetch and program load
    output mem_pkg::word_t                      rdata_a,
    input  wire mem_pkg::word_t                 wdata_a,
    input  wire logic [ADDR_WIDTH-1:0]          addr_a,
    input  wire logic                           wen_a,
    input  wire logic [mem_pkg::BEN_WIDTH-1:0]  ben_a,

    // port b, load/store unit
    output mem_pkg::word_t                      rdata_b,
    input  wire mem_pkg::word_t                 wdata_b,
    input  wire logic [ADDR_WIDTH-1:0]          addr_b,
    input  wire logic                           wen_b,
    input  wire logic [mem_pkg::BEN_WIDTH-1:0]  ben_b
);

    localparam int MEM_SIZE = 2 ** ADDR_WIDTH;

    // byte-wide storage
    logic [7:0] mem_array [MEM_SIZE];

    // port a wins, a port b write in the same cycle is lost
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < MEM_SIZE; i++) begin
                mem_array[i] <= '0;
            end
        end else if (wen_a) begin
            for (int lane = 0; lane < mem_pkg::BEN_WIDTH; lane++) begin
                if (ben_a[lane]) begin
                    mem_array[addr_a + ADDR_WIDTH'(lane)] <= wdata_a[lane*8 +: 8];
                end
            end
        end else if (wen_b) begin
            for (int lane = 0; lane < mem_pkg::BEN_WIDTH; lane++) begin
                if (ben_b[lane]) begin
                    mem_array[addr_b + ADDR_WIDTH'(lane)] <= wdata_b[lane*8 +: 8];
                end
            end
        end
    end

    // combinational reads, four bytes from the base address
    // addresses wrap at the top of the array
    for (genvar lane = 0; lane < mem_pkg::BEN_WIDTH; lane++) begin : g_read
        assign rdata_a[lane*8 +: 8] = mem_array[addr_a + ADDR_WIDTH'(lane)];
        assign rdata_b[lane*8 +: 8] = mem_array[addr_b + ADDR_WIDTH'(lane)];
    end

endmodule

`default_nettype wire

//--- logic/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter int ADDR_WIDTH = 8
) (
    input  wire logic                           clk,
    input  wire logic                           rst_n,
    input  wire logic                           run,
    input  wire logic                           redirect,
    input  wire logic [31:0]                    redirect_pc,

    // program loader
    input  wire logic                           prog_we,
    input  wire mem_pkg::prog_wr_t              prog_wr,

    // fetched instructions
    output logic                                fetch_valid,
    output mem_pkg::fetch_rsp_t                 fetch_rsp,

    // memory port a
    output logic [ADDR_WIDTH-1:0]               mem_addr,
    output mem_pkg::word_t                      mem_wdata,
    output logic                                mem_wen,
    output logic [mem_pkg::BEN_WIDTH-1:0]       mem_ben,
    input  wire mem_pkg::word_t                 mem_rdata
);

    logic [31:0] pc_q;
    logic        fetch_go;

    // a program write or a redirect takes the fetch slot
    assign fetch_go = run && !prog_we && !redirect;

    // port a belongs to the loader while it writes
    assign mem_addr  = prog_we ? prog_wr.addr[ADDR_WIDTH-1:0] : pc_q[ADDR_WIDTH-1:0];
    assign mem_wdata = prog_wr.data;
    assign mem_wen   = prog_we;
    assign mem_ben   = prog_wr.ben;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q        <= '0;
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= fetch_go;
            if (redirect) begin
                pc_q <= redirect_pc;
            end else if (fetch_go) begin
                pc_q <= pc_q + 32'd4;
            end
        end
    end

    // instruction word and its pc
    always_ff @(posedge clk) begin
        if (fetch_go) begin
            fetch_rsp.pc    <= pc_q;
            fetch_rsp.instr <= mem_rdata;
        end
    end

endmodule

`default_nettype wire

//--- logic/lsu.sv
`timescale 1ns/1ps
`default_nettype none

module lsu #(
    parameter int ADDR_WIDTH = 8
) (
    input  wire logic                           clk,
    input  wire logic                           rst_n,
    input  wire logic                           req_valid,
    input  wire mem_pkg::lsu_req_t              req,

    output logic                                rsp_valid,
    output mem_pkg::lsu_rsp_t                   rsp,

    // memory port b
    output logic [ADDR_WIDTH-1:0]               mem_addr,
    output mem_pkg::word_t                      mem_wdata,
    output logic                                mem_wen,
    output logic [mem_pkg::BEN_WIDTH-1:0]       mem_ben,
    input  wire mem_pkg::word_t                 mem_rdata
);

    typedef enum logic [1:0] {
        SIZE_B,
        SIZE_H,
        SIZE_W
    } size_e;

    size_e                         size;
    logic                          is_store;
    logic                          is_unsigned;
    logic                          misaligned;
    logic [1:0]                    offset;
    logic [4:0]                    shamt;
    logic [mem_pkg::BEN_WIDTH-1:0] ben_base;
    mem_pkg::word_t                lane_data;
    mem_pkg::word_t                load_data;

    // opcode decode
    always_comb begin
        size        = SIZE_W;
        is_store    = 1'b0;
        is_unsigned = 1'b0;
        case (req.op)
            mem_pkg::OP_LB:  size = SIZE_B;
            mem_pkg::OP_LH:  size = SIZE_H;
            mem_pkg::OP_LW:  size = SIZE_W;
            mem_pkg::OP_LBU: begin
                size        = SIZE_B;
                is_unsigned = 1'b1;
            end
            mem_pkg::OP_LHU: begin
                size        = SIZE_H;
                is_unsigned = 1'b1;
            end
            mem_pkg::OP_SB: begin
                size     = SIZE_B;
                is_store = 1'b1;
            end
            mem_pkg::OP_SH: begin
                size     = SIZE_H;
                is_store = 1'b1;
            end
            default: begin
                size     = SIZE_W;
                is_store = 1'b1;
            end
        endcase
    end

    assign offset = req.addr[1:0];
    assign shamt  = {offset, 3'b000};

    // halfwords on even bytes, words on multiples of four
    assign misaligned = (size == SIZE_H && offset[0]) || (size == SIZE_W && offset != 2'b00);

    always_comb begin
        case (size)
            SIZE_B:  ben_base = 4'b0001;
            SIZE_H:  ben_base = 4'b0011;
            default: ben_base = 4'b1111;
        endcase
    end

    // word-aligned access, lanes picked by the low address bits
    assign mem_addr  = {req.addr[ADDR_WIDTH-1:2], 2'b00};
    assign mem_ben   = ben_base << offset;
    assign mem_wdata = req.wdata << shamt;
    assign mem_wen   = req_valid && is_store && !misaligned;

    // align and extend the load
    assign lane_data = mem_rdata >> shamt;

    always_comb begin
        if (is_store || misaligned) begin
            load_data = '0;
        end else begin
            case (size)
                SIZE_B:  load_data = {{24{lane_data[7] & ~is_unsigned}}, lane_data[7:0]};
                SIZE_H:  load_data = {{16{lane_data[15] & ~is_unsigned}}, lane_data[15:0]};
                default: load_data = lane_data;
            endcase
        end
    end

    // one response per request, one cycle later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            rsp.rdata      <= load_data;
            rsp.misaligned <= misaligned;
        end
    end

endmodule

`default_nettype wire

//--- logic/mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys #(
    parameter int ADDR_WIDTH = 8
) (
    input  wire logic                   clk,
    input  wire logic                   rst_n,

    // program loader
    input  wire logic                   prog_we,
    input  wire mem_pkg::prog_wr_t      prog_wr,

    // instruction fetch
    input  wire logic                   run,
    input  wire logic                   redirect,
    input  wire logic [31:0]            redirect_pc,
    output logic                        fetch_valid,
    output mem_pkg::fetch_rsp_t         fetch_rsp,

    // load/store
    input  wire logic                   req_valid,
    input  wire mem_pkg::lsu_req_t      req,
    output logic                        rsp_valid,
    output mem_pkg::lsu_rsp_t           rsp
);

    // port a
    logic [ADDR_WIDTH-1:0]         addr_a;
    mem_pkg::word_t                wdata_a;
    mem_pkg::word_t                rdata_a;
    logic                          wen_a;
    logic [mem_pkg::BEN_WIDTH-1:0] ben_a;

    // port b
    logic [ADDR_WIDTH-1:0]         addr_b;
    mem_pkg::word_t                wdata_b;
    mem_pkg::word_t                rdata_b;
    logic                          wen_b;
    logic [mem_pkg::BEN_WIDTH-1:0] ben_b;

    fetch_unit #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_fetch_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .prog_we     (prog_we),
        .prog_wr     (prog_wr),
        .fetch_valid (fetch_valid),
        .fetch_rsp   (fetch_rsp),
        .mem_addr    (addr_a),
        .mem_wdata   (wdata_a),
        .mem_wen     (wen_a),
        .mem_ben     (ben_a),
        .mem_rdata   (rdata_a)
    );

    lsu #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_lsu (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .mem_addr  (addr_b),
        .mem_wdata (wdata_b),
        .mem_wen   (wen_b),
        .mem_ben   (ben_b),
        .mem_rdata (rdata_b)
    );

    mem #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .rdata_a (rdata_a),
        .wdata_a (wdata_a),
        .addr_a  (addr_a),
        .wen_a   (wen_a),
        .ben_a   (ben_a),
        .rdata_b (rdata_b),
        .wdata_b (wdata_b),
        .addr_b  (addr_b),
        .wen_b   (wen_b),
        .ben_b   (ben_b)
    );

endmodule

`default_nettype wire

//--- sim/mem_subsys_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_assertions (
    input wire logic              clk,
    input wire logic              rst_n,
    input wire logic              prog_we,
    input wire logic              redirect,
    input wire logic              fetch_valid,
    input wire logic              req_valid,
    input wire mem_pkg::lsu_req_t req,
    input wire logic              rsp_valid,
    input wire logic              wen_b
);

    logic half_op;
    logic word_op;
    logic req_misaligned;

    assign half_op = req.op == mem_pkg::OP_LH || req.op == mem_pkg::OP_LHU ||
                     req.op == mem_pkg::OP_SH;
    assign word_op = req.op == mem_pkg::OP_LW || req.op == mem_pkg::OP_SW;
    assign req_misaligned = (half_op && req.addr[0]) || (word_op && req.addr[1:0] != 2'b00);

    // one response per request, exactly one cycle later
    rsp_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid == $past(req_valid))
        else $error("rsp_valid does not follow req_valid by one cycle");

    // loader and redirect cycles issue no fetch
    no_fetch_after_block: assert property (@(posedge clk) disable iff (!rst_n)
        (prog_we || redirect) |=> !fetch_valid)
        else $error("fetch_valid after a program write or redirect");

    no_misaligned_write: assert property (@(posedge clk) disable iff (!rst_n)
        (req_valid && req_misaligned) |-> !wen_b)
        else $error("port b write on a misaligned request");

    quiet_in_reset: assert property (@(posedge clk) !rst_n |-> (!fetch_valid && !rsp_valid))
        else $error("valid output high during reset");

endmodule

bind mem_subsys mem_subsys_assertions u_mem_subsys_assertions (
    .clk         (clk),
    .rst_n       (rst_n),
    .prog_we     (prog_we),
    .redirect    (redirect),
    .fetch_valid (fetch_valid),
    .req_valid   (req_valid),
    .req         (req),
    .rsp_valid   (rsp_valid),
    .wen_b       (wen_b)
);

`default_nettype wire

//--- sim/tb_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;

    localparam int ADDR_WIDTH = 8;
    localparam int MEM_BYTES  = 2 ** ADDR_WIDTH;
    // reset plus the five tests, drain cycles included
    localparam int TEST_CYCLES = 17 + 23 + 51 + 67 + 31 + 11;

    logic                clk;
    logic                rst_n;
    logic                prog_we;
    mem_pkg::prog_wr_t   prog_wr;
    logic                run;
    logic                redirect;
    logic [31:0]         redirect_pc;
    logic                fetch_valid;
    mem_pkg::fetch_rsp_t fetch_rsp;
    logic                req_valid;
    mem_pkg::lsu_req_t   req;
    logic                rsp_valid;
    mem_pkg::lsu_rsp_t   rsp;

    // reference model state
    logic [7:0]          ref_mem [MEM_BYTES];
    logic [31:0]         model_pc;
    logic                run_next;
    logic [15:0]         lfsr;
    mem_pkg::fetch_rsp_t exp_fetch [$];
    mem_pkg::lsu_rsp_t   exp_rsp [$];
    int                  check_errors;
    int                  drain_errors;
    int                  check_count;
    int                  test_count;
    int                  failed_tests;

    mem_subsys #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_mem_subsys (
        .clk         (clk),
        .rst_n       (rst_n),
        .prog_we     (prog_we),
        .prog_wr     (prog_wr),
        .run         (run),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .fetch_valid (fetch_valid),
        .fetch_rsp   (fetch_rsp),
        .req_valid   (req_valid),
        .req         (req),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // galois lfsr, taps 16 14 13 11, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic int op_size(input mem_pkg::mem_op_e op);
        case (op)
            mem_pkg::OP_LB, mem_pkg::OP_LBU, mem_pkg::OP_SB: return 1;
            mem_pkg::OP_LH, mem_pkg::OP_LHU, mem_pkg::OP_SH: return 2;
            default: return 4;
        endcase
    endfunction

    function automatic logic is_store_op(input mem_pkg::mem_op_e op);
        return op == mem_pkg::OP_SB || op == mem_pkg::OP_SH || op == mem_pkg::OP_SW;
    endfunction

    function automatic mem_pkg::lsu_rsp_t expect_load(input mem_pkg::mem_op_e op,
                                                      input logic [31:0] addr);
        mem_pkg::lsu_rsp_t r;
        int                size;
        logic [31:0]       raw;
        size         = op_size(op);
        r.misaligned = (addr % size) != 0;
        // only the accessed bytes, so unsigned loads pass raw through
        raw = '0;
        for (int i = 0; i < size; i++) begin
            raw[i*8 +: 8] = ref_mem[ADDR_WIDTH'(addr + i)];
        end
        case (op)
            mem_pkg::OP_LB:  r.rdata = {{24{raw[7]}}, raw[7:0]};
            mem_pkg::OP_LH:  r.rdata = {{16{raw[15]}}, raw[15:0]};
            mem_pkg::OP_LW, mem_pkg::OP_LBU, mem_pkg::OP_LHU: r.rdata = raw;
            default: r.rdata = '0;
        endcase
        if (r.misaligned) r.rdata = '0;
        return r;
    endfunction

    function automatic mem_pkg::word_t model_word(input logic [31:0] addr);
        mem_pkg::word_t w;
        for (int i = 0; i < 4; i++) begin
            w[i*8 +: 8] = ref_mem[ADDR_WIDTH'(addr + i)];
        end
        return w;
    endfunction

    function automatic void model_write(input logic [31:0] addr, input mem_pkg::word_t data,
                                        input logic [3:0] ben);
        for (int i = 0; i < 4; i++) begin
            if (ben[i]) ref_mem[ADDR_WIDTH'(addr + i)] = data[i*8 +: 8];
        end
    endfunction

    function automatic int total_errors();
        return check_errors + drain_errors;
    endfunction

    // drive one cycle and predict what it produces
    task automatic drive_cycle(input logic pw, input mem_pkg::prog_wr_t pwr, input logic rd,
                               input logic [31:0] rpc, input logic rv,
                               input mem_pkg::lsu_req_t rq);
        mem_pkg::fetch_rsp_t f;
        mem_pkg::lsu_rsp_t   e;
        @(posedge clk);
        run         <= run_next;
        prog_we     <= pw;
        prog_wr     <= pwr;
        redirect    <= rd;
        redirect_pc <= rpc;
        req_valid   <= rv;
        req         <= rq;
        // reads see memory before the write at the end of the cycle
        if (run_next && !pw && !rd) begin
            f.pc    = model_pc;
            f.instr = model_word(model_pc);
            exp_fetch.push_back(f);
            model_pc = model_pc + 32'd4;
        end
        if (rd) model_pc = rpc;
        e = expect_load(rq.op, rq.addr);
        if (rv) exp_rsp.push_back(e);
        // port a write wins, the store is dropped
        if (pw) begin
            model_write(pwr.addr, pwr.data, pwr.ben);
        end else if (rv && is_store_op(rq.op) && !e.misaligned) begin
            model_write(rq.addr, rq.wdata, 4'((1 << op_size(rq.op)) - 1));
        end
    endtask

    task automatic idle();
        drive_cycle(1'b0, '0, 1'b0, '0, 1'b0, '0);
    endtask

    task automatic prog_write(input logic [31:0] addr, input mem_pkg::word_t data);
        mem_pkg::prog_wr_t p;
        p.addr = addr;
        p.data = data;
        p.ben  = 4'hF;
        drive_cycle(1'b1, p, 1'b0, '0, 1'b0, '0);
    endtask

    task automatic lsu_access(input mem_pkg::mem_op_e op, input logic [31:0] addr,
                              input mem_pkg::word_t wdata);
        mem_pkg::lsu_req_t q;
        q.op    = op;
        q.addr  = addr;
        q.wdata = wdata;
        drive_cycle(1'b0, '0, 1'b0, '0, 1'b1, q);
    endtask

    // random address in 0x80..0x9f, aligned to the access size
    function automatic logic [31:0] window_addr(input mem_pkg::mem_op_e op);
        logic [31:0] a;
        a = 32'h80 | rand_bits(5);
        return a & ~32'(op_size(op) - 1);
    endfunction

    task automatic finish_test(input string name, input int mark);
        int waited;
        waited = 0;
        idle();
        while ((exp_fetch.size() != 0 || exp_rsp.size() != 0) && waited < 8) begin
            idle();
            waited++;
        end
        @(negedge clk);
        if (exp_fetch.size() != 0 || exp_rsp.size() != 0) begin
            $display("%0t: test %s ended with responses the DUT never sent", $time, name);
            drain_errors++;
        end
        test_count++;
        if (total_errors() != mark) failed_tests++;
        $display("test %s: %s", name, (total_errors() == mark) ? "ok" : "failed");
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        mem_pkg::fetch_rsp_t f;
        mem_pkg::lsu_rsp_t   e;
        if (!rst_n) begin
            if (fetch_valid || rsp_valid) begin
                $display("%0t: a valid output is high during reset", $time);
                check_errors++;
            end
        end else begin
            if (fetch_valid) begin
                if (exp_fetch.size() == 0) begin
                    $display("%0t: fetch_valid pulsed with no fetch outstanding", $time);
                    check_errors++;
                end else begin
                    f = exp_fetch.pop_front();
                    check_count++;
                    if (fetch_rsp !== f) begin
                        $display("[FAIL] %0t: fetch pc %h instr %h, expected pc %h instr %h",
                                 $time, fetch_rsp.pc, fetch_rsp.instr, f.pc, f.instr);
                        check_errors++;
                    end
                end
            end
            if (rsp_valid) begin
                if (exp_rsp.size() == 0) begin
                    $display("%0t: rsp_valid pulsed with no request outstanding", $time);
                    check_errors++;
                end else begin
                    e = exp_rsp.pop_front();
                    check_count++;
                    if (rsp !== e) begin
                        $display("[FAIL] %0t: rsp rdata %h misaligned %b, expected %h %b",
                                 $time, rsp.rdata, rsp.misaligned, e.rdata, e.misaligned);
                        check_errors++;
                    end
                end
            end
        end
    end

    initial begin
        #(TEST_CYCLES * 10 * 2);
        $display("timeout: tests did not finish within %0d ns", TEST_CYCLES * 20);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        int                mark;
        logic [31:0]       a;
        mem_pkg::mem_op_e  op;
        mem_pkg::prog_wr_t pw;
        mem_pkg::lsu_req_t q;
        rst_n        = 1'b1;
        prog_we      = 1'b0;
        prog_wr      = '0;
        run          = 1'b0;
        redirect     = 1'b0;
        redirect_pc  = '0;
        req_valid    = 1'b0;
        req          = '0;
        run_next     = 1'b0;
        model_pc     = '0;
        lfsr         = 16'd36931;
        check_errors = 0;
        drain_errors = 0;
        check_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        for (int i = 0; i < MEM_BYTES; i++) ref_mem[i] = 8'h00;
        // real falling edge for the async reset
        #1 rst_n = 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        // memory cleared, no stray pulses
        mark = total_errors();
        repeat (4) idle();
        for (int i = 0; i < 16; i++) begin
            a = {24'd0, 6'(rand_bits(6)), 2'b00};
            lsu_access(mem_pkg::OP_LW, a, '0);
        end
        finish_test("reset", mark);

        mark     = total_errors();
        run_next = 1'b1;
        for (int i = 0; i < 16; i++) prog_write(32'(i * 4), rand_bits(32));
        repeat (20) idle();
        drive_cycle(1'b0, '0, 1'b1, 32'd12, 1'b0, '0);
        repeat (6) idle();
        prog_write(32'd200, rand_bits(32));
        repeat (4) idle();
        run_next = 1'b0;
        finish_test("prog_fetch", mark);

        mark = total_errors();
        for (int i = 0; i < 24; i++) begin
            op = mem_pkg::mem_op_e'(3'd5 + 3'(rand_bits(2) % 3));
            lsu_access(op, window_addr(op), rand_bits(32));
        end
        for (int i = 0; i < 40; i++) begin
            op = mem_pkg::mem_op_e'(3'(rand_bits(3) % 5));
            lsu_access(op, window_addr(op), '0);
        end
        finish_test("ld_st_width", mark);

        mark = total_errors();
        for (int i = 0; i < 20; i++) begin
            case (i % 5)
                0: op = mem_pkg::OP_LH;
                1: op = mem_pkg::OP_LHU;
                2: op = mem_pkg::OP_LW;
                3: op = mem_pkg::OP_SH;
                default: op = mem_pkg::OP_SW;
            endcase
            a = window_addr(mem_pkg::OP_LW);
            if (op_size(op) == 2) a = a + 32'(2 * rand_bits(1) + 1);
            else a = a + 32'(1 + rand_bits(2) % 3);
            lsu_access(op, a, rand_bits(32));
        end
        // memory in the window must be untouched
        for (int i = 0; i < 8; i++) lsu_access(mem_pkg::OP_LW, 32'h80 + 32'(i * 4), '0);
        finish_test("misaligned", mark);

        mark = total_errors();
        for (int i = 0; i < 4; i++) begin
            a       = window_addr(mem_pkg::OP_LW);
            pw.addr = a;
            pw.data = rand_bits(32);
            pw.ben  = 4'hF;
            q.op    = mem_pkg::OP_SW;
            q.addr  = a;
            q.wdata = rand_bits(32);
            drive_cycle(1'b1, pw, 1'b0, '0, 1'b1, q);
            lsu_access(mem_pkg::OP_LW, a, '0);
        end
        finish_test("priority", mark);

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 test_count, failed_tests, check_count, total_errors());
        if (total_errors() == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
logic/mem_pkg.sv
logic/mem.sv
logic/fetch_unit.sv
logic/lsu.sv
logic/mem_subsys.sv
sim/mem_subsys_assertions.sv
sim/tb_mem_subsys.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, and pass only when the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_mem_subsys -f list.f -o tb_mem_subsys \
    && ./obj_dir/tb_mem_subsys | tee /dev/stderr | grep -q "ALL TESTS PASSED" \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
